// ==== Bender.yml ====
package:
  name: master_stage

sources:
  - design/masterStagePkg.sv
  - design/addrDecode.sv
  - design/addrHold.sv
  - design/dataPhaseMux.sv
  - design/defaultSlave.sv
  - design/masterStage.sv
  - target: test
    files:
      - verif/masterStageTb.sv

// ==== design/addrDecode.sv ====
// Fixed map with no remap; slot values of numSlots and above are reported as reserved
module addrDecode
(
	input masterStagePkg::addrPhaseT addrPhase,
	output masterStagePkg::slotMaskT slotDec,
	output logic reservedDec
);

	logic [masterStagePkg::slotMsb-masterStagePkg::slotLsb:0] slotNum;

	assign slotNum = addrPhase.haddr[masterStagePkg::slotMsb:masterStagePkg::slotLsb];

	always_comb
	begin
		slotDec = '0;
		reservedDec = 1'b0;
		if (slotNum < masterStagePkg::numSlots)
		begin
			slotDec = masterStagePkg::slotMaskT'(1) << slotNum;
		end
		else
		begin
			// Nothing decodes here
			reservedDec = 1'b1;
		end
	end

endmodule

// ==== design/addrHold.sv ====
// Holds one address phase at a time; a disabled slot always counts as address-ready
module addrHold
(
	input logic HCLK,
	input logic HRESETN,
	input masterStagePkg::addrPhaseT masterAddr,
	input logic masterReady,
	input masterStagePkg::slotMaskT slotDec,
	input masterStagePkg::slaveReadArrT slaveRead,
	output masterStagePkg::addrPhaseT gatedAddr
);

	typedef enum logic
	{
		idleSt,
		heldSt
	} holdStateT;

	holdStateT holdState;
	holdStateT holdNext;
	masterStagePkg::addrPhaseT capAddr;
	masterStagePkg::slotMaskT addrReadyVec;
	logic captureEn;
	logic slaveStall;
	logic slaveAccept;

	// Default slave sits behind disabled slots and never stalls
	always_comb
	begin
		for (int i = 0; i < masterStagePkg::numSlots; i++)
		begin
			addrReadyVec[i] = slaveRead[i].addrReady | ~masterStagePkg::slotEnable[i];
		end
	end

	assign slaveStall = |(slotDec & ~addrReadyVec);
	assign slaveAccept = |(slotDec & addrReadyVec);

	// Master moves on while the slave is busy
	assign captureEn = (holdState == idleSt) && masterAddr.htrans && masterReady && slaveStall;

	always_comb
	begin
		holdNext = holdState;
		case (holdState)
			idleSt:
				if (captureEn)
					holdNext = heldSt;
			heldSt:
				if (slaveAccept)
					holdNext = idleSt;
			default:
				holdNext = idleSt;
		endcase
	end

	always_ff @(posedge HCLK or negedge HRESETN)
	begin
		if (!HRESETN)
			holdState <= idleSt;
		else
			holdState <= holdNext;
	end

	always_ff @(posedge HCLK)
	begin
		if (captureEn)
			capAddr <= masterAddr;
	end

	// Registered state picks the source, so no loop through the decoder
	assign gatedAddr = (holdState == heldSt) ? capAddr : masterAddr;

endmodule

// ==== design/dataPhaseMux.sv ====
// Response path is purely combinational from the data-phase select; disabled slots read zero
module dataPhaseMux
(
	input logic HCLK,
	input logic HRESETN,
	input masterStagePkg::slotMaskT addrSel,
	input logic reservedSel,
	input masterStagePkg::slaveReadArrT slaveRead,
	input logic defReady,
	input logic defResp,
	output masterStagePkg::slotMaskT dataSel,
	output logic defSelect,
	output logic dataSlaveReady,
	output masterStagePkg::masterRespT masterResp
);

	logic reservedData;

	// Select advances only when the previous data phase has ended
	always_ff @(posedge HCLK or negedge HRESETN)
	begin
		if (!HRESETN)
		begin
			dataSel <= '0;
			reservedData <= 1'b0;
		end
		else if (dataSlaveReady)
		begin
			dataSel <= addrSel;
			reservedData <= reservedSel;
		end
	end

	// Reserved region or a slot with nothing behind it
	assign defSelect = reservedData | (|(dataSel & ~masterStagePkg::slotEnable));

	always_comb
	begin
		masterResp.hready = 1'b1;
		masterResp.hresp = masterStagePkg::respOkay;
		masterResp.hrdata = '0;
		dataSlaveReady = 1'b1;
		if (defSelect)
		begin
			masterResp.hready = defReady;
			masterResp.hresp = defResp;
			dataSlaveReady = defReady;
		end
		else
		begin
			// Only enabled slots reach here
			for (int i = 0; i < masterStagePkg::numSlots; i++)
			begin
				if (dataSel[i])
				begin
					masterResp.hready = slaveRead[i].dataReady;
					masterResp.hresp = slaveRead[i].hresp;
					masterResp.hrdata = slaveRead[i].hrdata;
					dataSlaveReady = slaveRead[i].hreadyout;
				end
			end
		end
	end

	// Upstream gating and decode must keep this clean
	dataOneHot: assert property (@(posedge HCLK) disable iff (!HRESETN)
		$onehot0(dataSel))
		else $error("dataPhaseMux: data select %b is not one-hot", dataSel);

endmodule

// ==== design/defaultSlave.sv ====
// Answers every selected data phase with the two-cycle ERROR and never returns read data
module defaultSlave
(
	input logic HCLK,
	input logic HRESETN,
	input logic defSelect,
	output logic defReady,
	output logic defResp
);

	typedef enum logic
	{
		idleSt,
		errSecondSt
	} defStateT;

	defStateT defState;
	defStateT defNext;

	always_comb
	begin
		defNext = idleSt;
		defReady = 1'b1;
		defResp = masterStagePkg::respOkay;
		case (defState)
			idleSt:
				if (defSelect)
				begin
					// First error cycle stalls the master
					defReady = 1'b0;
					defResp = masterStagePkg::respError;
					defNext = errSecondSt;
				end
			errSecondSt:
				defResp = masterStagePkg::respError;
			default:
				defNext = idleSt;
		endcase
	end

	always_ff @(posedge HCLK or negedge HRESETN)
	begin
		if (!HRESETN)
			defState <= idleSt;
		else
			defState <= defNext;
	end

endmodule

// ==== design/masterStage.sv ====
// Single master to four slots; slave-side signals are only meaningful while addrSel is set
module masterStage
(
	input logic HCLK,
	input logic HRESETN,
	input masterStagePkg::addrPhaseT masterAddr,
	output masterStagePkg::masterRespT masterResp,
	input masterStagePkg::slaveReadArrT slaveRead,
	output masterStagePkg::addrPhaseT gatedAddr,
	output masterStagePkg::slotMaskT addrSel,
	output masterStagePkg::slotMaskT dataSel,
	output logic dataSlaveReady
);

	masterStagePkg::slotMaskT slotDec;
	logic reservedDec;
	logic reservedSel;
	logic defSelect;
	logic defReady;
	logic defResp;

	addrHold i_addrHold (
		.HCLK(HCLK),
		.HRESETN(HRESETN),
		.masterAddr(masterAddr),
		.masterReady(masterResp.hready),
		.slotDec(slotDec),
		.slaveRead(slaveRead),
		.gatedAddr(gatedAddr)
	);

	addrDecode i_addrDecode (
		.addrPhase(gatedAddr),
		.slotDec(slotDec),
		.reservedDec(reservedDec)
	);

	// Idle transfers select nothing
	assign addrSel = gatedAddr.htrans ? slotDec : '0;
	assign reservedSel = gatedAddr.htrans & reservedDec;

	dataPhaseMux i_dataPhaseMux (
		.HCLK(HCLK),
		.HRESETN(HRESETN),
		.addrSel(addrSel),
		.reservedSel(reservedSel),
		.slaveRead(slaveRead),
		.defReady(defReady),
		.defResp(defResp),
		.dataSel(dataSel),
		.defSelect(defSelect),
		.dataSlaveReady(dataSlaveReady),
		.masterResp(masterResp)
	);

	defaultSlave i_defaultSlave (
		.HCLK(HCLK),
		.HRESETN(HRESETN),
		.defSelect(defSelect),
		.defReady(defReady),
		.defResp(defResp)
	);

endmodule

// ==== design/masterStagePkg.sv ====
// Four slots only, decoded from HADDR[31:28]; HTRANS is carried as its active bit alone
package masterStagePkg;

	localparam int numSlots = 4;

	// Slot number is the top address nibble
	localparam int slotMsb = 31;
	localparam int slotLsb = 28;

	// Slot 2 has no slave behind it
	localparam logic [numSlots-1:0] slotEnable = 4'b1011;

	localparam logic respOkay = 1'b0;
	localparam logic respError = 1'b1;

	// One-hot or all zero
	typedef logic [numSlots-1:0] slotMaskT;

	// Address phase as driven by the master
	typedef struct packed {
		logic [31:0] haddr;
		logic htrans;
		logic hwrite;
		logic [2:0] hsize;
		logic hmastlock;
	} addrPhaseT;

	typedef struct packed {
		logic hready;
		logic hresp;
		logic [31:0] hrdata;
	} masterRespT;

	// Per-slave return path
	typedef struct packed {
		logic [31:0] hrdata;
		logic hreadyout;
		logic dataReady;
		logic addrReady;
		logic hresp;
	} slaveReadT;

	typedef slaveReadT [numSlots-1:0] slaveReadArrT;

endpackage

// ==== project.f ====
design/masterStagePkg.sv
design/addrDecode.sv
design/addrHold.sv
design/dataPhaseMux.sv
design/defaultSlave.sv
design/masterStage.sv
verif/masterStageTb.sv

// ==== verif/masterStageTb.sv ====
// One transfer in flight at a time; the slave model stalls only the addressed slot, others stay ready
module masterStageTb;

	localparam int numRows = 10;
	localparam int resetCycles = 4;
	localparam int cycleLimit = numRows * 40 + resetCycles;
	localparam logic [31:0] dataPattern = 32'hC0DE_5A00;

	typedef struct packed
	{
		logic [31:0] addr;
		logic write;
		masterStagePkg::slotMaskT expSel;
		logic expResp;
		logic [31:0] expData;
	} rowT;

	logic HCLK;
	logic HRESETN;
	masterStagePkg::addrPhaseT masterAddr;
	masterStagePkg::masterRespT masterResp;
	masterStagePkg::slaveReadArrT slaveRead;
	masterStagePkg::addrPhaseT gatedAddr;
	masterStagePkg::slotMaskT addrSel;
	masterStagePkg::slotMaskT dataSel;
	logic dataSlaveReady;

	rowT rows [numRows];
	string rowNames [numRows];
	int addrWaits [numRows];
	int dataWaits [numRows];
	int seed = 79026;
	int mismatches = 0;
	int checks = 0;
	int cycleCount = 0;

	// Slave model state
	// A target of -1 leaves every slot ready
	int target;
	int addrLeft;
	int dataLeft;
	logic inData;

	masterStage i_masterStage (
		.HCLK(HCLK),
		.HRESETN(HRESETN),
		.masterAddr(masterAddr),
		.masterResp(masterResp),
		.slaveRead(slaveRead),
		.gatedAddr(gatedAddr),
		.addrSel(addrSel),
		.dataSel(dataSel),
		.dataSlaveReady(dataSlaveReady)
	);

	always #4 HCLK = ~HCLK;

	always @(posedge HCLK)
	begin
		cycleCount++;
		if (cycleCount > cycleLimit)
		begin
			$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("Some tests failed");
			$finish;
		end
	end

	function automatic masterStagePkg::masterRespT respValue(input logic ready, input logic resp,
		input logic [31:0] data);
		masterStagePkg::masterRespT r;
		r.hready = ready;
		r.hresp = resp;
		r.hrdata = data;
		return r;
	endfunction

	function automatic masterStagePkg::addrPhaseT addrPhase(input logic [31:0] addr,
		input logic active, input logic write);
		masterStagePkg::addrPhaseT a;
		a.haddr = addr;
		a.htrans = active;
		a.hwrite = write;
		a.hsize = 3'b010;
		a.hmastlock = 1'b0;
		return a;
	endfunction

	task automatic compareResp(input string testName, input masterStagePkg::masterRespT expResp,
		input masterStagePkg::masterRespT actResp);
		checks++;
		if (actResp !== expResp)
		begin
			mismatches++;
			$display("Mismatch %s: masterResp expected %b/%b/%h actual %b/%b/%h", testName,
				expResp.hready, expResp.hresp, expResp.hrdata,
				actResp.hready, actResp.hresp, actResp.hrdata);
		end
	endtask

	task automatic compareReady(input string testName, input logic expReady,
		input logic actReady);
		checks++;
		if (actReady !== expReady)
		begin
			mismatches++;
			$display("Mismatch %s: dataSlaveReady expected %b actual %b", testName,
				expReady, actReady);
		end
	endtask

	task automatic checkSelect(input string testName, input string what,
		input masterStagePkg::slotMaskT expSel, input masterStagePkg::slotMaskT actSel);
		checks++;
		if (actSel !== expSel)
		begin
			mismatches++;
			$display("Mismatch %s: %s expected %b actual %b", testName, what, expSel, actSel);
		end
	endtask

	task automatic verifyGatedAddr(input string testName, input masterStagePkg::addrPhaseT expAddr,
		input masterStagePkg::addrPhaseT actAddr);
		checks++;
		if (actAddr !== expAddr)
		begin
			mismatches++;
			$display("Mismatch %s: gatedAddr expected %h actual %h", testName, expAddr, actAddr);
		end
	endtask

	task automatic driveSlaves();
		for (int i = 0; i < masterStagePkg::numSlots; i++)
		begin
			slaveRead[i].hrdata = dataPattern | i;
			slaveRead[i].hresp = masterStagePkg::respOkay;
			slaveRead[i].addrReady = (i != target) || inData || addrLeft == 0;
			slaveRead[i].dataReady = (i != target) || (inData && dataLeft == 0);
			slaveRead[i].hreadyout = (i != target) || (inData && dataLeft == 0);
		end
	endtask

	// Address wait first, then the data phase starts and counts its own waits
	task automatic advanceSlaves();
		if (inData)
		begin
			if (dataLeft > 0)
				dataLeft--;
		end
		else if (addrLeft == 0)
			inData = 1'b1;
		else
			addrLeft--;
		driveSlaves();
	endtask

	task automatic addRow(input int idx, input string name, input logic [31:0] addr,
		input logic write, input masterStagePkg::slotMaskT sel, input logic resp,
		input logic [31:0] data);
		rowNames[idx] = name;
		rows[idx] = '{addr, write, sel, resp, data};
		addrWaits[idx] = $unsigned($random(seed)) % 4;
		dataWaits[idx] = $unsigned($random(seed)) % 4;
	endtask

	task automatic loadTable();
		addRow(0, "read slot 0", 32'h0000_0040, 1'b0, 4'b0001, 1'b0, dataPattern | 0);
		addRow(1, "read slot 1", 32'h1000_0104, 1'b0, 4'b0010, 1'b0, dataPattern | 1);
		addRow(2, "read slot 3", 32'h3000_0010, 1'b0, 4'b1000, 1'b0, dataPattern | 3);
		addRow(3, "disabled slot 2", 32'h2000_0000, 1'b0, 4'b0100, 1'b1, 32'h0);
		addRow(4, "reserved slot 4", 32'h4000_0000, 1'b0, 4'b0000, 1'b1, 32'h0);
		addRow(5, "write slot 0", 32'h0FFF_FFFC, 1'b1, 4'b0001, 1'b0, dataPattern | 0);
		addRow(6, "read slot 3 again", 32'h3ABC_0000, 1'b0, 4'b1000, 1'b0, dataPattern | 3);
		addRow(7, "reserved slot 15", 32'hF000_0008, 1'b0, 4'b0000, 1'b1, 32'h0);
		addRow(8, "read slot 1 again", 32'h1234_5678, 1'b0, 4'b0010, 1'b0, dataPattern | 1);
		addRow(9, "write slot 2", 32'h2000_0100, 1'b1, 4'b0100, 1'b1, 32'h0);
	endtask

	task automatic runRow(input int r);
		masterStagePkg::addrPhaseT rowAddr;
		masterStagePkg::addrPhaseT idleAddr;
		logic isErr;
		logic held;
		logic done;
		int cyc;
		rowAddr = addrPhase(rows[r].addr, 1'b1, rows[r].write);
		idleAddr = addrPhase(rows[r].addr + 32'h100, 1'b0, 1'b0);
		isErr = rows[r].expResp == masterStagePkg::respError;
		target = -1;
		for (int i = 0; i < masterStagePkg::numSlots; i++)
			if (rows[r].expSel[i] && !isErr)
				target = i;
		addrLeft = addrWaits[r];
		dataLeft = dataWaits[r];
		inData = 1'b0;
		@(negedge HCLK);
		masterAddr = rowAddr;
		driveSlaves();
		#2;
		checkSelect(rowNames[r], "addrSel", rows[r].expSel, addrSel);
		verifyGatedAddr(rowNames[r], rowAddr, gatedAddr);
		// Master moves on at once while the data phase runs until hready
		cyc = 1;
		done = 1'b0;
		while (!done)
		begin
			@(negedge HCLK);
			masterAddr = idleAddr;
			advanceSlaves();
			#2;
			held = !isErr && cyc <= addrWaits[r];
			verifyGatedAddr(rowNames[r], held ? rowAddr : idleAddr, gatedAddr);
			checkSelect(rowNames[r], "addrSel",
				held ? rows[r].expSel : masterStagePkg::slotMaskT'(0), addrSel);
			checkSelect(rowNames[r], "dataSel", rows[r].expSel, dataSel);
			if (isErr && cyc == 1)
			begin
				compareResp(rowNames[r], respValue(1'b0, masterStagePkg::respError, 32'h0),
					masterResp);
				compareReady(rowNames[r], 1'b0, dataSlaveReady);
			end
			else if (!isErr && !(inData && dataLeft == 0))
			begin
				compareResp(rowNames[r], respValue(1'b0, masterStagePkg::respOkay,
					rows[r].expData), masterResp);
				compareReady(rowNames[r], 1'b0, dataSlaveReady);
			end
			else
			begin
				compareResp(rowNames[r], respValue(1'b1, rows[r].expResp, rows[r].expData),
					masterResp);
				compareReady(rowNames[r], 1'b1, dataSlaveReady);
				done = 1'b1;
			end
			cyc++;
		end
		// Idle cycle after the transfer
		target = -1;
		@(negedge HCLK);
		driveSlaves();
		#2;
		checkSelect(rowNames[r], "idle addrSel", '0, addrSel);
		checkSelect(rowNames[r], "idle dataSel", '0, dataSel);
		compareResp(rowNames[r], respValue(1'b1, masterStagePkg::respOkay, 32'h0), masterResp);
		compareReady(rowNames[r], 1'b1, dataSlaveReady);
	endtask

	initial
	begin
		HCLK = 1'b0;
		HRESETN = 1'b0;
		masterAddr = addrPhase(32'h0, 1'b0, 1'b0);
		target = -1;
		addrLeft = 0;
		dataLeft = 0;
		inData = 1'b0;
		driveSlaves();
		loadTable();
		repeat (resetCycles) @(posedge HCLK);
		@(negedge HCLK);
		HRESETN = 1'b1;
		#2;
		checkSelect("reset", "addrSel", '0, addrSel);
		checkSelect("reset", "dataSel", '0, dataSel);
		compareResp("reset", respValue(1'b1, masterStagePkg::respOkay, 32'h0), masterResp);
		compareReady("reset", 1'b1, dataSlaveReady);
		for (int r = 0; r < numRows; r++)
			runRow(r);
		$display("Errors: %0d mismatches in %0d checks", mismatches, checks);
		if (mismatches == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule
